/* source/io_map_pkg.sv */
// Mailbox memory map
// Word addresses of the controller mailboxes shared by the host and the poller,
// and the step encoding of the fixed poll schedule
package io_map_pkg;

	// Words the poller fetches for the controllers
	localparam int unsigned SPI_DIN_ADDR   = 0;	// SPI transmit byte in bits 7:0
	localparam int unsigned SPI_CTRL_ADDR  = 1;	// SPI control word
	localparam int unsigned UART_DIN_ADDR  = 2;	// UART transmit byte
	localparam int unsigned UART_CTRL_ADDR = 3;	// UART control word

	// Words the poller writes back
	localparam int unsigned SPI_STAT_ADDR  = 32;	// SPI busy and done
	localparam int unsigned SPI_DOUT_ADDR  = 33;	// Last received SPI byte
	localparam int unsigned UART_STAT_ADDR = 34;	// UART busy and done

	// Everything else in the array is general host storage

	// Poll schedule, one granted access per step, wraps after the last
	typedef enum logic [2:0] {
		STEP_SPI_DIN,	// Read SPI data-in
		STEP_SPI_CTRL,	// Read SPI control
		STEP_SPI_STAT,	// Write SPI status
		STEP_SPI_DOUT,	// Write SPI received byte
		STEP_UART_DIN,	// Read UART data-in
		STEP_UART_CTRL,	// Read UART control
		STEP_UART_STAT	// Write UART status
	} poll_step_e;

endpackage

/* source/io_ctrl_pkg.sv */
// Controller word fields
// Bit positions and widths of the control and status words used by the
// SPI master and the UART transmitter
package io_ctrl_pkg;

	// Control word, common part
	localparam int unsigned CTRL_GO_BIT = 0;	// Transfer starts when this bit changes

	// SPI control word
	// SCK half period in clocks, zero behaves as one
	localparam int unsigned SPI_DIV_LSB = 8;
	localparam int unsigned SPI_DIV_W   = 8;

	// UART control word
	// Bit period in clocks, zero behaves as one
	localparam int unsigned UART_DIV_LSB = 16;
	localparam int unsigned UART_DIV_W   = 16;

	// Status word, same layout for both controllers
	localparam int unsigned STAT_BUSY_BIT = 0;	// Frame in progress
	localparam int unsigned STAT_DONE_BIT = 1;	// Set at frame end, cleared by next start

endpackage

/* source/mbox_bus_if.sv */
// Mailbox memory bus
// One requester's access to the shared word memory: request, write enable,
// address, write data, read data and grant
`timescale 1ns/100ps

interface mbox_bus_if #(
	parameter int ADDR_W = 6
);
	logic              req;	// Access request, held until gnt
	logic              we;	// Whole-word write when high
	logic [ADDR_W-1:0] addr;	// Word address
	logic [31:0]       wdata;
	logic [31:0]       rdata;	// Valid the cycle after a granted read
	logic              gnt;	// Access accepted this cycle

	// Side that starts accesses
	modport requester (output req, we, addr, wdata, input rdata, gnt);

	// Side that serves accesses
	modport memory (input req, we, addr, wdata, output rdata, gnt);

endinterface

/* source/mbox_ram.sv */
// Mailbox memory
// Single-port word array with synchronous write and registered read.
// Contents are not initialized.
`timescale 1ns/100ps

module mbox_ram #(
	parameter int ADDR_W = 6
) (
	input  logic       clk,
	mbox_bus_if.memory mem_bus
);
	logic [31:0] mem_q [0:(1 << ADDR_W) - 1];
	logic [31:0] rdata_q;

	assign mem_bus.gnt = mem_bus.req;	// Every access done in one cycle

	always_ff @(posedge clk) begin
		if (mem_bus.req) begin
			if (mem_bus.we)
				mem_q[mem_bus.addr] <= mem_bus.wdata;
			else
				rdata_q <= mem_q[mem_bus.addr];	// Old data kept on writes
		end
	end

	assign mem_bus.rdata = rdata_q;

endmodule

/* source/mbox_arbiter.sv */
// Mailbox arbiter
// Fixed priority between the host and the poller on the single memory port.
// The host always wins, the poller only gets idle host cycles.
`timescale 1ns/100ps

module mbox_arbiter #(
	parameter int ADDR_W = 6
) (
	input  logic          clk,
	input  logic          nrst,
	mbox_bus_if.memory    host_bus,
	mbox_bus_if.memory    poll_bus,
	mbox_bus_if.requester mem_bus
);
	logic              poll_sel;	// Poller owns the port this cycle
	logic [ADDR_W-1:0] addr_mux;
	logic              host_rd_q;	// Host read in flight
	logic              poll_rd_q;	// Poller read in flight

	assign poll_sel = poll_bus.req & ~host_bus.req;

	// Port mux, host first
	assign addr_mux      = host_bus.req ? host_bus.addr : poll_bus.addr;
	assign mem_bus.req   = host_bus.req | poll_bus.req;
	assign mem_bus.we    = host_bus.req ? host_bus.we : poll_bus.we;
	assign mem_bus.addr  = addr_mux;
	assign mem_bus.wdata = host_bus.req ? host_bus.wdata : poll_bus.wdata;

	assign host_bus.gnt = host_bus.req & mem_bus.gnt;	// Host never waits
	assign poll_bus.gnt = poll_sel & mem_bus.gnt;

	// Remember who issued the read so the data lands on its bus
	always_ff @(posedge clk) begin
		if (!nrst) begin
			host_rd_q <= 1'b0;
			poll_rd_q <= 1'b0;
		end else begin
			host_rd_q <= host_bus.gnt & ~host_bus.we;
			poll_rd_q <= poll_bus.gnt & ~poll_bus.we;
		end
	end

	assign host_bus.rdata = host_rd_q ? mem_bus.rdata : '0;
	assign poll_bus.rdata = poll_rd_q ? mem_bus.rdata : '0;

endmodule

/* source/ctrl_poller.sv */
// Controller poller
// Walks the fixed schedule through the mailbox: fetches data-in and control
// words for the controllers, writes their status and received data back.
// A read is captured in the following step, so two accesses overlap.
`timescale 1ns/100ps

module ctrl_poller #(
	parameter int ADDR_W = 6
) (
	input  logic          clk,
	input  logic          nrst,
	mbox_bus_if.requester poll_bus,
	output logic [7:0]    spi_din_o,
	output logic [31:0]   spi_ctrl_o,
	input  logic [31:0]   spi_stat_i,
	input  logic [31:0]   spi_dout_i,
	output logic [7:0]    uart_din_o,
	output logic [31:0]   uart_ctrl_o,
	input  logic [31:0]   uart_stat_i
);
	io_map_pkg::poll_step_e step_q;	// Current schedule step
	io_map_pkg::poll_step_e pend_dst_q;	// Step whose read data returns now
	logic                   pend_vld_q;	// Read data due this cycle

	// Access of the current step
	always_comb begin
		poll_bus.req   = 1'b1;	// Always something to do
		poll_bus.we    = 1'b0;
		poll_bus.addr  = '0;
		poll_bus.wdata = '0;
		case (step_q)
			io_map_pkg::STEP_SPI_DIN:   poll_bus.addr = ADDR_W'(io_map_pkg::SPI_DIN_ADDR);
			io_map_pkg::STEP_SPI_CTRL:  poll_bus.addr = ADDR_W'(io_map_pkg::SPI_CTRL_ADDR);
			io_map_pkg::STEP_SPI_STAT: begin
				poll_bus.we    = 1'b1;
				poll_bus.addr  = ADDR_W'(io_map_pkg::SPI_STAT_ADDR);
				poll_bus.wdata = spi_stat_i;
			end
			io_map_pkg::STEP_SPI_DOUT: begin
				poll_bus.we    = 1'b1;
				poll_bus.addr  = ADDR_W'(io_map_pkg::SPI_DOUT_ADDR);
				poll_bus.wdata = spi_dout_i;
			end
			io_map_pkg::STEP_UART_DIN:  poll_bus.addr = ADDR_W'(io_map_pkg::UART_DIN_ADDR);
			io_map_pkg::STEP_UART_CTRL: poll_bus.addr = ADDR_W'(io_map_pkg::UART_CTRL_ADDR);
			io_map_pkg::STEP_UART_STAT: begin
				poll_bus.we    = 1'b1;
				poll_bus.addr  = ADDR_W'(io_map_pkg::UART_STAT_ADDR);
				poll_bus.wdata = uart_stat_i;
			end
			default: poll_bus.we = 1'b0;	// Unused encoding, harmless read of word 0
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			step_q      <= io_map_pkg::STEP_SPI_DIN;
			pend_dst_q  <= io_map_pkg::STEP_SPI_DIN;
			pend_vld_q  <= 1'b0;
			spi_din_o   <= '0;
			spi_ctrl_o  <= '0;
			uart_din_o  <= '0;
			uart_ctrl_o <= '0;
		end else begin
			pend_vld_q <= poll_bus.gnt & ~poll_bus.we;
			if (poll_bus.gnt) begin	// Stall here under host traffic
				pend_dst_q <= step_q;
				if (step_q == io_map_pkg::STEP_UART_STAT)
					step_q <= io_map_pkg::STEP_SPI_DIN;
				else
					step_q <= io_map_pkg::poll_step_e'(step_q + 3'd1);
			end
			// Capture last step's read
			if (pend_vld_q) begin
				case (pend_dst_q)
					io_map_pkg::STEP_SPI_DIN:   spi_din_o   <= poll_bus.rdata[7:0];
					io_map_pkg::STEP_SPI_CTRL:  spi_ctrl_o  <= poll_bus.rdata;
					io_map_pkg::STEP_UART_DIN:  uart_din_o  <= poll_bus.rdata[7:0];
					io_map_pkg::STEP_UART_CTRL: uart_ctrl_o <= poll_bus.rdata;
					default: ;	// Write steps bring nothing back
				endcase
			end
		end
	end

endmodule

/* source/spi_master.sv */
// SPI master
// Mode 0, 8-bit frames MSB first, one slave select. SCK half period comes
// from the control word. Done stays set until the next start.
`timescale 1ns/100ps

module spi_master (
	input  logic        clk,
	input  logic        nrst,
	input  logic [7:0]  din_i,
	input  logic [31:0] ctrl_i,
	output logic [31:0] stat_o,
	output logic [31:0] dout_o,
	output logic        sck_o,
	output logic        mosi_o,
	input  logic        miso_i,
	output logic        ss_n_o
);
	logic [io_ctrl_pkg::SPI_DIV_W-1:0] div_new;	// Divider field of ctrl_i
	logic [io_ctrl_pkg::SPI_DIV_W-1:0] div_q;	// Divider latched at start
	logic [io_ctrl_pkg::SPI_DIV_W-1:0] div_cnt_q;
	logic [4:0] edge_q;	// Half periods done, 16 edges then deselect
	logic [7:0] sr_q;	// Out on top, in at bottom
	logic       rx_q;	// MISO sampled on rising SCK
	logic       go_q, busy_q, done_q;
	logic       sck_q, ss_n_q;
	logic       start, tick;

	assign div_new = ctrl_i[io_ctrl_pkg::SPI_DIV_LSB +: io_ctrl_pkg::SPI_DIV_W];
	assign start   = ~busy_q & (ctrl_i[io_ctrl_pkg::CTRL_GO_BIT] != go_q);
	assign tick    = busy_q & (div_cnt_q == div_q - 1'b1);	// End of a half period

	always_ff @(posedge clk) begin
		if (!nrst) begin
			go_q <= 1'b0;
			busy_q <= 1'b0;
			done_q <= 1'b0;
			div_q <= '0;
			div_cnt_q <= '0;
			edge_q <= '0;
			sr_q <= '0;
			rx_q <= 1'b0;
			sck_q <= 1'b0;
			ss_n_q <= 1'b1;
		end else if (start) begin
			go_q      <= ctrl_i[io_ctrl_pkg::CTRL_GO_BIT];	// Accept this go value
			busy_q    <= 1'b1;
			done_q    <= 1'b0;
			ss_n_q    <= 1'b0;	// First bit on MOSI right away
			div_q     <= (div_new == '0) ? 1'b1 : div_new;
			div_cnt_q <= '0;
			edge_q    <= '0;
			sr_q      <= din_i;
		end else if (busy_q) begin
			div_cnt_q <= tick ? '0 : div_cnt_q + 1'b1;
			if (tick) begin
				edge_q <= edge_q + 5'd1;
				if (edge_q == 5'd16) begin	// Half period after last falling edge
					busy_q <= 1'b0;
					done_q <= 1'b1;
					ss_n_q <= 1'b1;
				end else begin
					sck_q <= ~sck_q;
					if (!sck_q)
						rx_q <= miso_i;	// Rising edge
					else
						sr_q <= {sr_q[6:0], rx_q};	// Falling edge, next bit out
				end
			end
		end
	end

	always_comb begin
		stat_o = '0;
		stat_o[io_ctrl_pkg::STAT_BUSY_BIT] = busy_q;
		stat_o[io_ctrl_pkg::STAT_DONE_BIT] = done_q;
	end

	assign dout_o = {24'd0, sr_q};	// Received byte once done
	assign sck_o  = sck_q;
	assign mosi_o = sr_q[7];
	assign ss_n_o = ss_n_q;

endmodule

/* source/uart_tx.sv */
// UART transmitter
// 8N1 frames, LSB first, bit period in clocks from the control word.
// Done stays set until the next start.
`timescale 1ns/100ps

module uart_tx (
	input  logic        clk,
	input  logic        nrst,
	input  logic [7:0]  din_i,
	input  logic [31:0] ctrl_i,
	output logic [31:0] stat_o,
	output logic        tx_o
);
	logic [io_ctrl_pkg::UART_DIV_W-1:0] div_new;
	logic [io_ctrl_pkg::UART_DIV_W-1:0] div_q;	// Bit period latched at start
	logic [io_ctrl_pkg::UART_DIV_W-1:0] per_cnt_q;
	logic [9:0] frame_q;	// Stop, data, start, bit 0 on the line
	logic [3:0] bit_q;	// Bit currently on the line
	logic       go_q, busy_q, done_q;
	logic       start, tick;

	assign div_new = ctrl_i[io_ctrl_pkg::UART_DIV_LSB +: io_ctrl_pkg::UART_DIV_W];
	assign start   = ~busy_q & (ctrl_i[io_ctrl_pkg::CTRL_GO_BIT] != go_q);
	assign tick    = busy_q & (per_cnt_q == div_q - 1'b1);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			go_q <= 1'b0;
			busy_q <= 1'b0;
			done_q <= 1'b0;
			div_q <= '0;
			per_cnt_q <= '0;
			bit_q <= '0;
			frame_q <= '1;	// Line idles high
		end else if (start) begin
			go_q      <= ctrl_i[io_ctrl_pkg::CTRL_GO_BIT];
			busy_q    <= 1'b1;
			done_q    <= 1'b0;
			div_q     <= (div_new == '0) ? 1'b1 : div_new;
			per_cnt_q <= '0;
			bit_q     <= '0;
			frame_q   <= {1'b1, din_i, 1'b0};
		end else if (busy_q) begin
			per_cnt_q <= tick ? '0 : per_cnt_q + 1'b1;
			if (tick) begin
				if (bit_q == 4'd9) begin	// End of stop bit
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end else begin
					bit_q   <= bit_q + 4'd1;
					frame_q <= {1'b1, frame_q[9:1]};	// Fill with idle level
				end
			end
		end
	end

	always_comb begin
		stat_o = '0;
		stat_o[io_ctrl_pkg::STAT_BUSY_BIT] = busy_q;
		stat_o[io_ctrl_pkg::STAT_DONE_BIT] = done_q;
	end

	assign tx_o = frame_q[0];

endmodule

/* source/io_mbox_top.sv */
// Polled mailbox I/O subsystem
// Host port and controller poller share one word memory through a fixed
// priority arbiter. The poller feeds an SPI master and a UART transmitter.
`timescale 1ns/100ps

module io_mbox_top #(
	parameter int ADDR_W = 6
) (
	input  logic              clk,
	input  logic              nrst,
	input  logic              host_req_i,
	input  logic              host_we_i,
	input  logic [ADDR_W-1:0] host_addr_i,
	input  logic [31:0]       host_wdata_i,
	output logic [31:0]       host_rdata_o,
	output logic              sck_o,
	output logic              mosi_o,
	input  logic              miso_i,
	output logic              ss_n_o,
	output logic              uart_tx_o,
	output logic [1:0]        irq_o	// {SPI done, UART done}
);
	mbox_bus_if #(.ADDR_W(ADDR_W)) host_bus ();
	mbox_bus_if #(.ADDR_W(ADDR_W)) poll_bus ();
	mbox_bus_if #(.ADDR_W(ADDR_W)) mem_bus ();

	logic [7:0]  spi_din, uart_din;
	logic [31:0] spi_ctrl, spi_stat, spi_dout;
	logic [31:0] uart_ctrl, uart_stat;

	// Host pins onto its bus
	assign host_bus.req   = host_req_i;
	assign host_bus.we    = host_we_i;
	assign host_bus.addr  = host_addr_i;
	assign host_bus.wdata = host_wdata_i;
	assign host_rdata_o   = host_bus.rdata;

	mbox_ram #(.ADDR_W(ADDR_W)) u_ram (.clk(clk), .mem_bus(mem_bus));

	mbox_arbiter #(.ADDR_W(ADDR_W)) u_arb (
		.clk(clk), .nrst(nrst),
		.host_bus(host_bus), .poll_bus(poll_bus), .mem_bus(mem_bus)
	);

	ctrl_poller #(.ADDR_W(ADDR_W)) u_poll (
		.clk(clk), .nrst(nrst), .poll_bus(poll_bus),
		.spi_din_o(spi_din), .spi_ctrl_o(spi_ctrl),
		.spi_stat_i(spi_stat), .spi_dout_i(spi_dout),
		.uart_din_o(uart_din), .uart_ctrl_o(uart_ctrl), .uart_stat_i(uart_stat)
	);

	spi_master u_spi (
		.clk(clk), .nrst(nrst), .din_i(spi_din), .ctrl_i(spi_ctrl),
		.stat_o(spi_stat), .dout_o(spi_dout),
		.sck_o(sck_o), .mosi_o(mosi_o), .miso_i(miso_i), .ss_n_o(ss_n_o)
	);

	uart_tx u_uart (
		.clk(clk), .nrst(nrst), .din_i(uart_din), .ctrl_i(uart_ctrl),
		.stat_o(uart_stat), .tx_o(uart_tx_o)
	);

	// Done levels straight from the status words
	assign irq_o = {spi_stat[io_ctrl_pkg::STAT_DONE_BIT], uart_stat[io_ctrl_pkg::STAT_DONE_BIT]};

endmodule

/* verif/tb_io_mbox.sv */
// Testbench for the polled mailbox I/O subsystem
// Host traffic against a mirror, SPI slave and UART line models,
// status and interrupt checks under host back-pressure
`timescale 1ns/100ps

module tb_io_mbox;
	localparam int ADDR_W = 6;
	localparam int WORDS  = 1 << ADDR_W;

	logic        clk, nrst;
	logic        host_req, host_we;
	logic [ADDR_W-1:0] host_addr;
	logic [31:0] host_wdata, host_rdata;
	logic        sck, mosi, miso, ss_n, uart_tx;
	logic [1:0]  irq;

	logic [31:0] mirror [0:WORDS-1];	// Host view of the memory
	logic [15:0] lfsr;
	logic        pend_rd, pend_chk, due_rd, due_chk;	// Read in flight and whether it is checked
	logic [31:0] pend_exp, due_exp;
	logic [7:0]  spi_reply, reply_sr, spi_got;
	logic [7:0]  uart_sr, uart_got;
	logic        sck_prev = 1'b0;
	logic        ss_prev = 1'b1;
	int          sck_gap = 0;	// Clocks since the last SCK or select edge
	int          spi_starts = 0;
	int          uart_starts = 0;
	int          spi_div, uart_div;
	int          cycles = 0;
	int          limit;

	io_mbox_top #(.ADDR_W(ADDR_W)) u_dut (
		.clk(clk), .nrst(nrst),
		.host_req_i(host_req), .host_we_i(host_we), .host_addr_i(host_addr),
		.host_wdata_i(host_wdata), .host_rdata_o(host_rdata),
		.sck_o(sck), .mosi_o(mosi), .miso_i(miso), .ss_n_o(ss_n),
		.uart_tx_o(uart_tx), .irq_o(irq)
	);

	always #4 clk = ~clk;

	// Galois LFSR stepped once for every bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic poller_word(input int a);
		return a == io_map_pkg::SPI_STAT_ADDR || a == io_map_pkg::SPI_DOUT_ADDR ||
			a == io_map_pkg::UART_STAT_ADDR;
	endfunction

	function automatic logic general_word(input int a);
		return a > io_map_pkg::UART_CTRL_ADDR && !poller_word(a);
	endfunction

	// Expected mailbox word for a status, the received byte or a host word
	function automatic logic [31:0] expect_word(input int a, input logic done,
			input logic [7:0] reply);
		if (a == io_map_pkg::SPI_STAT_ADDR || a == io_map_pkg::UART_STAT_ADDR)
			return {30'd0, done, 1'b0};	// Done in bit 1, busy in bit 0
		else if (a == io_map_pkg::SPI_DOUT_ADDR)
			return {24'd0, reply};
		return mirror[a];
	endfunction

	function automatic logic [31:0] ctrl_word(input int div, input int lsb, input logic go);
		logic [31:0] w;
		w = 32'(div) << lsb;
		w[io_ctrl_pkg::CTRL_GO_BIT] = go;
		return w;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL at time %0d ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// One host cycle driven on the falling edge
	task automatic host_step(input logic req, input logic we, input int addr,
			input logic [31:0] wdata);
		@(negedge clk);
		host_req   = req;
		host_we    = we;
		host_addr  = ADDR_W'(addr);
		host_wdata = wdata;
		pend_rd    = req & ~we;
		pend_chk   = !poller_word(addr);
		pend_exp   = expect_word(addr, 1'b0, 8'd0);
		if (req && we)
			mirror[addr] = wdata;
	endtask

	task automatic host_idle(input int n);
		repeat (n) host_step(1'b0, 1'b0, 0, '0);
	endtask

	task automatic host_write(input int addr, input logic [31:0] data);
		host_step(1'b1, 1'b1, addr, data);
		host_idle(1);
	endtask

	task automatic host_read(input int addr, output logic [31:0] data);
		host_step(1'b1, 1'b0, addr, '0);
		host_idle(1);
		data = host_rdata;	// One cycle after the request
	endtask

	// Back-to-back random accesses that stall the poller
	task automatic host_burst(input int n);
		int   a;
		logic we;
		repeat (n) begin
			a = rand_bits(ADDR_W);
			while (!general_word(a))
				a = rand_bits(ADDR_W);
			we = rand_bits(1);
			host_step(1'b1, we, a, rand_bits(32));
		end
		host_idle(1);
	endtask

	task automatic wait_stat(input int addr, input int bitpos, output logic [31:0] d);
		d = '0;
		while (d[bitpos] !== 1'b1)
			host_read(addr, d);
	endtask

	task automatic spi_transfer(input logic go, input logic burst);
		int          n0;
		logic [31:0] rd;
		n0 = spi_starts;
		spi_reply = rand_bits(8);
		host_write(io_map_pkg::SPI_CTRL_ADDR, ctrl_word(spi_div, io_ctrl_pkg::SPI_DIV_LSB, go));
		if (burst) begin
			while (spi_starts == n0)
				host_idle(1);
			host_burst(40);
		end else begin
			wait_stat(io_map_pkg::SPI_STAT_ADDR, io_ctrl_pkg::STAT_BUSY_BIT, rd);
			check_eq(rd[io_ctrl_pkg::STAT_DONE_BIT], 1'b0, "SPI done still set while busy");
		end
		wait_stat(io_map_pkg::SPI_STAT_ADDR, io_ctrl_pkg::STAT_DONE_BIT, rd);
		check_eq(irq[1], 1'b1, "SPI interrupt level");
		host_idle(8);	// Poller writes the received byte one step after status
		host_read(io_map_pkg::SPI_STAT_ADDR, rd);
		check_eq(rd, expect_word(io_map_pkg::SPI_STAT_ADDR, 1'b1, spi_reply), "SPI status word");
		host_read(io_map_pkg::SPI_DOUT_ADDR, rd);
		check_eq(rd, expect_word(io_map_pkg::SPI_DOUT_ADDR, 1'b1, spi_reply),
			"SPI reply in mailbox");
		check_eq(spi_got, mirror[io_map_pkg::SPI_DIN_ADDR][7:0], "byte seen by SPI slave");
		check_eq(spi_starts, n0 + 1, "SPI frame count");
	endtask

	task automatic uart_transfer(input logic go, input logic burst);
		int          n0;
		logic [31:0] rd;
		n0 = uart_starts;
		host_write(io_map_pkg::UART_CTRL_ADDR,
			ctrl_word(uart_div, io_ctrl_pkg::UART_DIV_LSB, go));
		if (burst) begin
			while (uart_starts == n0)
				host_idle(1);
			host_burst(40);
		end else begin
			wait_stat(io_map_pkg::UART_STAT_ADDR, io_ctrl_pkg::STAT_BUSY_BIT, rd);
			check_eq(rd[io_ctrl_pkg::STAT_DONE_BIT], 1'b0, "UART done still set while busy");
		end
		wait_stat(io_map_pkg::UART_STAT_ADDR, io_ctrl_pkg::STAT_DONE_BIT, rd);
		check_eq(irq[0], 1'b1, "UART interrupt level");
		check_eq(rd, expect_word(io_map_pkg::UART_STAT_ADDR, 1'b1, 8'd0), "UART status word");
		check_eq(uart_got, mirror[io_map_pkg::UART_DIN_ADDR][7:0], "byte decoded from UART line");
		check_eq(uart_starts, n0 + 1, "UART frame count");
	endtask

	// Host read data compared one cycle after the request
	always @(posedge clk) begin
		due_rd  <= pend_rd;
		due_chk <= pend_chk;
		due_exp <= pend_exp;
	end

	always @(negedge clk)
		if (due_rd && due_chk)
			check_eq(host_rdata, due_exp, "host read data");

	// Mode 0 SPI slave with the reply out on falling SCK and MOSI in on rising SCK
	// Every SCK edge and the select release come one divider after the edge before
	always @(negedge clk) begin
		if (ss_prev && !ss_n) begin
			miso       <= spi_reply[7];	// First bit before the first rising edge
			reply_sr   <= {spi_reply[6:0], 1'b0};
			spi_starts <= spi_starts + 1;
		end else if (!ss_n && sck_prev && !sck) begin
			miso     <= reply_sr[7];
			reply_sr <= {reply_sr[6:0], 1'b0};
		end
		if (!ss_n && !sck_prev && sck)
			spi_got <= {spi_got[6:0], mosi};
		if ((!ss_n && sck_prev != sck) || (ss_n && !ss_prev))
			check_eq(sck_gap, spi_div, "SCK edge spacing");
		if ((!ss_n && sck_prev != sck) || ss_prev != ss_n)
			sck_gap <= 1;
		else
			sck_gap <= sck_gap + 1;
		sck_prev <= sck;
		ss_prev  <= ss_n;
	end

	// UART line model sampling near mid-bit
	always begin
		@(negedge clk);
		if (nrst === 1'b1 && uart_tx === 1'b0) begin
			uart_starts <= uart_starts + 1;
			repeat ((uart_div - 1) / 2) @(negedge clk);
			check_eq(uart_tx, 1'b0, "UART start bit");
			for (int i = 0; i < 8; i++) begin
				repeat (uart_div) @(negedge clk);
				uart_sr[i] = uart_tx;	// LSB first
			end
			repeat (uart_div) @(negedge clk);
			check_eq(uart_tx, 1'b1, "UART stop bit");
			uart_got <= uart_sr;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	initial begin
		logic [31:0] rd;
		int          n_spi, n_uart;
		clk = 1'b0;
		nrst = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		miso = 1'b0;
		pend_rd = 1'b0;
		pend_chk = 1'b0;
		pend_exp = '0;
		lfsr = 16'd75;
		spi_div  = 1 + rand_bits(2);
		uart_div = 4 + rand_bits(4);
		limit = 2 * (2 * 17 * spi_div + 2 * 10 * uart_div) + 2000;	// Two frames each
		repeat (16) @(negedge clk);
		nrst = 1'b1;

		for (int a = 0; a <= io_map_pkg::UART_CTRL_ADDR; a++)
			host_write(a, '0);	// Go bits low before the poller fetches
		// General area written and read back against the mirror
		for (int a = 0; a < WORDS; a++)
			if (general_word(a))
				host_write(a, rand_bits(32));
		for (int a = 0; a < WORDS; a++)
			if (general_word(a))
				host_read(a, rd);

		// Frames under host back-pressure
		host_write(io_map_pkg::SPI_DIN_ADDR, rand_bits(32));
		spi_transfer(1'b1, 1'b1);
		host_write(io_map_pkg::UART_DIN_ADDR, rand_bits(32));
		uart_transfer(1'b1, 1'b1);

		// Control rewritten with the same go value
		n_spi = spi_starts;
		n_uart = uart_starts;
		host_write(io_map_pkg::SPI_CTRL_ADDR,
			ctrl_word(spi_div, io_ctrl_pkg::SPI_DIV_LSB, 1'b1));
		host_write(io_map_pkg::UART_CTRL_ADDR,
			ctrl_word(uart_div, io_ctrl_pkg::UART_DIV_LSB, 1'b1));
		host_idle(40);
		check_eq(spi_starts, n_spi, "SPI frame without a go change");
		check_eq(uart_starts, n_uart, "UART frame without a go change");
		check_eq(ss_n, 1'b1, "SPI select idle");
		check_eq(uart_tx, 1'b1, "UART line idle");

		// Go toggled back for one more frame each
		spi_transfer(1'b0, 1'b0);
		uart_transfer(1'b0, 1'b0);
		check_eq(irq, 2'b11, "both interrupt levels");
		host_idle(4);
		$display("All tests passed");
		$finish;
	end

endmodule

/* sim.f */
source/io_map_pkg.sv
source/io_ctrl_pkg.sv
source/mbox_bus_if.sv
source/mbox_ram.sv
source/mbox_arbiter.sv
source/ctrl_poller.sv
source/spi_master.sv
source/uart_tx.sv
source/io_mbox_top.sv
verif/tb_io_mbox.sv
